//--- bench/ooo_backend_tb.sv
`default_nettype none

module ooo_backend_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import core_types_pkg::*;

  localparam int STALL_TIMEOUT = 200;  // Cycles one instruction may wait
  localparam int DRAIN_TIMEOUT = 500;

  typedef struct packed {
    fu_op_t                  op;
    logic [GPR_IDX_SIZE-1:0] dst;
    logic [GPR_IDX_SIZE-1:0] src1;
    logic [GPR_IDX_SIZE-1:0] src2;
    logic                    use_imm;
    logic [IMM_SIZE-1:0]     imm;
    int                      gap;  // Idle cycles after dispatch
  } instr_t;

  typedef struct packed {
    logic [GPR_IDX_SIZE-1:0] gpr;
    logic [GPR_SIZE-1:0]     value;
    logic                    set_nzcv;
    nzcv_t                   nzcv;
  } expect_t;

  logic                    in_clk;
  logic                    in_rst_n;
  logic                    dispatch_valid;
  fu_op_t                  op;
  logic [GPR_IDX_SIZE-1:0] dst;
  logic [GPR_IDX_SIZE-1:0] src1;
  logic [GPR_IDX_SIZE-1:0] src2;
  logic                    use_imm;
  logic [IMM_SIZE-1:0]     imm;
  logic                    stall;
  logic                    commit_valid;
  logic [GPR_IDX_SIZE-1:0] commit_gpr;
  logic [GPR_SIZE-1:0]     commit_value;
  logic                    commit_set_nzcv;
  nzcv_t                   commit_nzcv;
  nzcv_t                   flags;

  instr_t              prog [$];
  expect_t             expect_q [$];
  expect_t             mon_exp;
  logic [GPR_SIZE-1:0] model_gpr [GPR_COUNT];
  nzcv_t               exp_flags;
  bit                  mon_enable;
  int                  seed;
  int                  stall_cycles;
  int                  waited;

  ooo_backend_top dut0 (
    .in_clk          (in_clk),
    .in_rst_n        (in_rst_n),
    .dispatch_valid  (dispatch_valid),
    .op              (op),
    .dst             (dst),
    .src1            (src1),
    .src2            (src2),
    .use_imm         (use_imm),
    .imm             (imm),
    .stall           (stall),
    .commit_valid    (commit_valid),
    .commit_gpr      (commit_gpr),
    .commit_value    (commit_value),
    .commit_set_nzcv (commit_set_nzcv),
    .commit_nzcv     (commit_nzcv),
    .flags           (flags)
  );

  initial begin
    in_clk = 1'b0;
    forever #5 in_clk = ~in_clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("[ERROR] t=%0t %s: got %h expected %h", $time, name, got, expected);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic add_instr(input fu_op_t op_i, input int dst_i, input int src1_i,
                           input int src2_i, input bit imm_sel, input int imm_i,
                           input int gap_i);
    instr_t ins;
    ins.op      = op_i;
    ins.dst     = dst_i;
    ins.src1    = src1_i;
    ins.src2    = src2_i;
    ins.use_imm = imm_sel;
    ins.imm     = imm_i;
    ins.gap     = gap_i;
    prog.push_back(ins);
  endtask

  // Mostly low registers, now and then the zero register
  function automatic int pick_reg();
    int v;
    v = $unsigned($random(seed)) % 16;
    return (v == 15) ? 31 : v;
  endfunction

  task automatic build_program();
    int op_sel;
    int d;
    int s1;
    int s2;
    int sel;
    int im;
    int g;
    // Independent work, x31 written and read back as zero
    add_instr(OP_MOVZ, 1, 0, 0, 1, 16'h1234, 2);
    add_instr(OP_MOVZ, 2, 0, 0, 1, 16'hABCD, 1);
    add_instr(OP_ADD, 3, 4, 0, 1, 5, 3);
    add_instr(OP_MOVZ, 31, 0, 0, 1, 16'h0077, 2);
    add_instr(OP_ADD, 5, 31, 0, 1, 1, 1);
    add_instr(OP_ADD, 6, 31, 31, 0, 0, 4);
    // RAW chains back to back
    add_instr(OP_ADD, 7, 1, 0, 1, 1, 0);
    add_instr(OP_ADD, 7, 7, 0, 1, 1, 0);
    add_instr(OP_SUB, 8, 7, 1, 0, 0, 0);
    add_instr(OP_ORR, 9, 8, 2, 0, 0, 0);
    add_instr(OP_AND, 10, 9, 2, 0, 0, 0);
    add_instr(OP_ADD, 11, 10, 10, 0, 0, 2);
    add_instr(OP_SUB, 11, 11, 7, 0, 0, 1);
    add_instr(OP_ADD, 11, 11, 0, 1, 16'h00FF, 3);
    // Flags: zero, negative, carry
    add_instr(OP_SUB, 13, 31, 0, 1, 1, 0);     // All ones
    add_instr(OP_ADDS, 14, 13, 0, 1, 1, 0);    // Z and C
    add_instr(OP_SUBS, 15, 12, 0, 1, 1, 1);    // N, borrow
    add_instr(OP_SUBS, 16, 1, 1, 0, 0, 2);     // Z, no borrow
    // Doubling chain up to the sign bit, long enough to stall
    add_instr(OP_MOVZ, 17, 0, 0, 1, 16'h8000, 0);
    for (int i = 0; i < 48; i++) begin
      add_instr(OP_ADD, 17, 17, 17, 0, 0, 0);
    end
    add_instr(OP_SUBS, 18, 17, 0, 1, 1, 0);    // Overflow to positive
    add_instr(OP_ADDS, 19, 18, 0, 1, 1, 0);    // Overflow to negative
    add_instr(OP_ADDS, 20, 17, 17, 0, 0, 3);   // Z, C and V together
    for (int i = 0; i < 40; i++) begin
      op_sel = $unsigned($random(seed)) % 7;
      d      = pick_reg();
      s1     = pick_reg();
      s2     = pick_reg();
      sel    = $unsigned($random(seed)) % 2;
      im     = $unsigned($random(seed)) % 65536;
      g      = $unsigned($random(seed)) % 4;
      add_instr(fu_op_t'(op_sel), d, s1, s2, sel[0], im, g);
    end
  endtask

  function automatic logic [GPR_SIZE-1:0] read_gpr(input logic [GPR_IDX_SIZE-1:0] idx);
    return (idx == 5'd31) ? '0 : model_gpr[idx];
  endfunction

  // Program-order reference, one call per accepted instruction
  task automatic model_dispatch(input instr_t ins);
    logic [GPR_SIZE-1:0] a;
    logic [GPR_SIZE-1:0] b;
    logic [GPR_SIZE-1:0] res;
    logic                c;
    logic                v;
    expect_t             e;
    a = read_gpr(ins.src1);
    b = ins.use_imm ? {{(GPR_SIZE - IMM_SIZE){1'b0}}, ins.imm} : read_gpr(ins.src2);
    c = 1'b0;
    v = 1'b0;
    case (ins.op)
      OP_ADD, OP_ADDS: begin
        res = a + b;
        c   = (res < a);  // Wrapped means carry out
        v   = (a[63] == b[63]) && (res[63] != a[63]);
      end
      OP_SUB, OP_SUBS: begin
        res = a - b;
        c   = (a >= b);
        v   = (a[63] != b[63]) && (res[63] != a[63]);
      end
      OP_AND:  res = a & b;
      OP_ORR:  res = a | b;
      default: res = b;
    endcase
    e.gpr      = ins.dst;
    e.value    = res;
    e.set_nzcv = (ins.op == OP_ADDS) || (ins.op == OP_SUBS);
    e.nzcv     = {res[63], (res == '0), c, v};
    expect_q.push_back(e);
    if (ins.dst != 5'd31) model_gpr[ins.dst] = res;
  endtask

  task automatic dispatch_instr(input instr_t ins);
    int wait_cnt;
    wait_cnt       = 0;
    dispatch_valid = 1'b1;
    op             = ins.op;
    dst            = ins.dst;
    src1           = ins.src1;
    src2           = ins.src2;
    use_imm        = ins.use_imm;
    imm            = ins.imm;
    @(negedge in_clk);
    while (stall) begin  // Hold the instruction
      stall_cycles++;
      wait_cnt++;
      if (wait_cnt > STALL_TIMEOUT)
        report_failure("Timeout: stall stayed high while an instruction was waiting");
      @(negedge in_clk);
    end
    model_dispatch(ins);
    @(posedge in_clk);
    #1;
    dispatch_valid = 1'b0;
    repeat (ins.gap) begin
      @(posedge in_clk);
      #1;
    end
  endtask

  always @(negedge in_clk) begin
    if (mon_enable && !in_rst_n) begin
      check_value("commit_valid", commit_valid, 1'b0);
      check_value("stall", stall, 1'b0);
      check_value("flags", flags, 4'h0);
    end else if (mon_enable) begin
      check_value("flags", flags, exp_flags);
      if (commit_valid) begin
        if (expect_q.size() == 0)
          report_failure("A commit appeared with no instruction left to commit");
        mon_exp = expect_q.pop_front();
        check_value("commit_gpr", commit_gpr, mon_exp.gpr);
        check_value("commit_value", commit_value, mon_exp.value);
        check_value("commit_set_nzcv", commit_set_nzcv, mon_exp.set_nzcv);
        if (mon_exp.set_nzcv) begin
          check_value("commit_nzcv", commit_nzcv, mon_exp.nzcv);
          exp_flags = mon_exp.nzcv;  // Flag register follows next edge
        end
      end
    end
  end

  initial begin
    seed           = 74883;
    dispatch_valid = 1'b0;
    op             = OP_ADD;
    dst            = '0;
    src1           = '0;
    src2           = '0;
    use_imm        = 1'b0;
    imm            = '0;
    exp_flags      = '0;
    stall_cycles   = 0;
    mon_enable     = 1'b0;
    for (int i = 0; i < GPR_COUNT; i++) model_gpr[i] = '0;
    in_rst_n = 1'b1;
    #1;
    in_rst_n   = 1'b0;
    mon_enable = 1'b1;
    repeat (8) @(posedge in_clk);
    #1;
    in_rst_n = 1'b1;
    // Idle state right after reset
    check_value("stall", stall, 1'b0);
    check_value("commit_valid", commit_valid, 1'b0);
    build_program();
    foreach (prog[i]) dispatch_instr(prog[i]);
    waited = 0;
    while (expect_q.size() != 0) begin
      waited++;
      if (waited > DRAIN_TIMEOUT)
        report_failure("Timeout: not every dispatched instruction was committed");
      @(negedge in_clk);
    end
    repeat (6) @(negedge in_clk);  // Catch stray commits
    if (stall_cycles == 0)
      report_failure("Stall never rose during the dependent burst");
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- common/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

  localparam int GPR_SIZE     = 64;
  localparam int GPR_COUNT    = 32;
  localparam int GPR_IDX_SIZE = 5;
  localparam int IMM_SIZE     = 16;  // Zero-extended to GPR_SIZE

  // Highest register reads as zero and drops writes
  localparam logic [GPR_IDX_SIZE-1:0] ZERO_GPR = GPR_IDX_SIZE'(GPR_COUNT - 1);

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_ORR,
    OP_ADDS,  // Writes NZCV
    OP_SUBS,  // Writes NZCV
    OP_MOVZ
  } fu_op_t;

endpackage

`default_nettype wire

//--- common/rob_pkg.sv
`default_nettype none

package rob_pkg;

  localparam int ROB_SIZE     = 8;
  localparam int ROB_IDX_SIZE = 3;

  // Wait slots in the execution station
  localparam int STATION_SIZE = 4;

  typedef struct packed {
    logic                                    busy;   // Allocated
    logic                                    valid;  // Result arrived
    logic [core_types_pkg::GPR_IDX_SIZE-1:0] gpr_index;
    logic                                    set_nzcv;
    logic [core_types_pkg::GPR_SIZE-1:0]     value;
    core_types_pkg::nzcv_t                   nzcv;
  } rob_entry_t;

endpackage

`default_nettype wire

//--- compile.f
common/core_types_pkg.sv
common/rob_pkg.sv
rob/rob.sv
src/reg_rename.sv
src/exec_station.sv
src/ooo_backend_top.sv
bench/ooo_backend_tb.sv

//--- rob/rob.sv
`default_nettype none

module rob (
  input  logic                                    in_clk,
  input  logic                                    in_rst_n,
  // Allocation request from rename
  input  logic                                    alloc_valid,
  input  logic [core_types_pkg::GPR_IDX_SIZE-1:0] alloc_gpr,
  input  logic                                    alloc_set_nzcv,
  // Sources held in the dispatch register
  input  logic                                    ren_src_a_ready,
  input  logic [core_types_pkg::GPR_SIZE-1:0]     ren_src_a_value,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]        ren_src_a_tag,
  input  logic                                    ren_src_b_ready,
  input  logic [core_types_pkg::GPR_SIZE-1:0]     ren_src_b_value,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]        ren_src_b_tag,
  // ALU result
  input  logic                                    fu_done,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]        fu_rob_index,
  input  logic [core_types_pkg::GPR_SIZE-1:0]     fu_value,
  input  logic                                    fu_set_nzcv,
  input  core_types_pkg::nzcv_t                   fu_nzcv,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]        rob_next_index,
  output logic                                    rob_full,
  // Forwarded operands to the station
  output logic                                    op_a_valid,
  output logic [core_types_pkg::GPR_SIZE-1:0]     op_a_value,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]        op_a_tag,
  output logic                                    op_b_valid,
  output logic [core_types_pkg::GPR_SIZE-1:0]     op_b_value,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]        op_b_tag,
  // Broadcast, one cycle after fu_done
  output logic                                    bc_valid,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]        bc_index,
  output logic [core_types_pkg::GPR_SIZE-1:0]     bc_value,
  output logic                                    bc_set_nzcv,
  output core_types_pkg::nzcv_t                   bc_nzcv,
  // In-order commit
  output logic                                    commit_valid,
  output logic [core_types_pkg::GPR_IDX_SIZE-1:0] commit_gpr,
  output logic [core_types_pkg::GPR_SIZE-1:0]     commit_value,
  output logic                                    commit_set_nzcv,
  output core_types_pkg::nzcv_t                   commit_nzcv,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]        commit_rob_index
);
  import core_types_pkg::*;
  import rob_pkg::*;

  rob_entry_t              entries [ROB_SIZE];
  logic [ROB_IDX_SIZE-1:0] head;   // Oldest entry
  logic [ROB_IDX_SIZE-1:0] tail;   // Next to allocate
  logic [ROB_IDX_SIZE:0]   count;

  // Ready source, else finished entry, else same-cycle broadcast
  function automatic logic [GPR_SIZE:0] forward(input logic                    ready,
                                                input logic [GPR_SIZE-1:0]     value,
                                                input logic [ROB_IDX_SIZE-1:0] tag);
    if (ready) return {1'b1, value};
    if (entries[tag].valid) return {1'b1, entries[tag].value};
    if (bc_valid && bc_index == tag) return {1'b1, bc_value};
    return {1'b0, value};
  endfunction

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      entries  <= '{default: '0};
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      bc_valid <= 1'b0;
      bc_index <= '0;
    end else begin
      if (fu_done) begin
        entries[fu_rob_index].valid <= 1'b1;
        entries[fu_rob_index].value <= fu_value;
        if (fu_set_nzcv) entries[fu_rob_index].nzcv <= fu_nzcv;
      end
      if (commit_valid) begin
        entries[head].busy  <= 1'b0;
        entries[head].valid <= 1'b0;
        head                <= head + 1'b1;  // Power-of-two size wraps naturally
      end
      if (alloc_valid) begin
        entries[tail].busy      <= 1'b1;
        entries[tail].valid     <= 1'b0;
        entries[tail].gpr_index <= alloc_gpr;
        entries[tail].set_nzcv  <= alloc_set_nzcv;
        tail                    <= tail + 1'b1;
      end
      count    <= count + (ROB_IDX_SIZE + 1)'(alloc_valid) - (ROB_IDX_SIZE + 1)'(commit_valid);
      bc_valid <= fu_done;
      bc_index <= fu_rob_index;
    end
  end

  always_comb begin
    {op_a_valid, op_a_value} = forward(ren_src_a_ready, ren_src_a_value, ren_src_a_tag);
    {op_b_valid, op_b_value} = forward(ren_src_b_ready, ren_src_b_value, ren_src_b_tag);
  end

  assign op_a_tag       = ren_src_a_tag;
  assign op_b_tag       = ren_src_b_tag;
  assign rob_next_index = tail;
  assign rob_full       = (count == (ROB_IDX_SIZE + 1)'(ROB_SIZE));

  // Result was latched at the previous edge
  assign bc_value    = entries[bc_index].value;
  assign bc_set_nzcv = entries[bc_index].set_nzcv;
  assign bc_nzcv     = entries[bc_index].nzcv;

  assign commit_valid     = entries[head].busy & entries[head].valid;
  assign commit_gpr       = entries[head].gpr_index;
  assign commit_value     = entries[head].value;
  assign commit_set_nzcv  = entries[head].set_nzcv;
  assign commit_nzcv      = entries[head].nzcv;
  assign commit_rob_index = head;

endmodule

`default_nettype wire

//--- src/exec_station.sv
`default_nettype none

module exec_station (
  input  logic                                in_clk,
  input  logic                                in_rst_n,
  input  logic                                ren_valid,
  input  core_types_pkg::fu_op_t              ren_op,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]    ren_rob_index,
  input  logic                                op_a_valid,
  input  logic [core_types_pkg::GPR_SIZE-1:0] op_a_value,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]    op_a_tag,
  input  logic                                op_b_valid,
  input  logic [core_types_pkg::GPR_SIZE-1:0] op_b_value,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]    op_b_tag,
  input  logic                                bc_valid,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]    bc_index,
  input  logic [core_types_pkg::GPR_SIZE-1:0] bc_value,
  output logic                                station_full,
  output logic                                fu_done,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]    fu_rob_index,
  output logic [core_types_pkg::GPR_SIZE-1:0] fu_value,
  output logic                                fu_set_nzcv,
  output core_types_pkg::nzcv_t               fu_nzcv
);
  import core_types_pkg::*;
  import rob_pkg::*;

  typedef logic [$clog2(STATION_SIZE)-1:0] slot_t;

  logic [STATION_SIZE-1:0] valid;
  logic [STATION_SIZE-1:0] a_ready;
  logic [STATION_SIZE-1:0] b_ready;
  logic [STATION_SIZE-1:0] free;
  fu_op_t                  slot_op  [STATION_SIZE];
  logic [ROB_IDX_SIZE-1:0] slot_rob [STATION_SIZE];
  logic [ROB_IDX_SIZE-1:0] a_tag    [STATION_SIZE];
  logic [ROB_IDX_SIZE-1:0] b_tag    [STATION_SIZE];
  logic [GPR_SIZE-1:0]     a_value  [STATION_SIZE];
  logic [GPR_SIZE-1:0]     b_value  [STATION_SIZE];
  slot_t                   age      [STATION_SIZE];  // Rank, 0 is youngest

  logic                        issue_valid;
  slot_t                       issue_sel;
  slot_t                       wr_sel;
  logic [$clog2(STATION_SIZE):0] n_free;

  fu_op_t              alu_op;
  logic [GPR_SIZE-1:0] alu_a;
  logic [GPR_SIZE-1:0] alu_b;
  logic [GPR_SIZE:0]   alu_sum;  // Top bit is carry out
  logic                alu_v;

  logic                    s1_valid;
  logic [ROB_IDX_SIZE-1:0] s1_rob;
  logic [GPR_SIZE-1:0]     s1_result;
  logic                    s1_c;
  logic                    s1_v;
  logic                    s1_set;

  // Oldest slot with both operands ready
  always_comb begin
    issue_valid = 1'b0;
    issue_sel   = '0;
    for (int i = 0; i < STATION_SIZE; i++) begin
      if (valid[i] && a_ready[i] && b_ready[i] &&
          (!issue_valid || age[i] > age[issue_sel])) begin
        issue_valid = 1'b1;
        issue_sel   = slot_t'(i);
      end
    end
  end

  // A slot issuing now is free for the next write
  always_comb begin
    wr_sel = '0;
    n_free = '0;
    for (int i = STATION_SIZE - 1; i >= 0; i--) begin
      free[i] = !valid[i] || (issue_valid && issue_sel == slot_t'(i));
      if (free[i]) begin
        wr_sel = slot_t'(i);
        n_free = n_free + 1'b1;
      end
    end
  end

  // Pending ren_valid already owns one free slot
  assign station_full = (n_free == '0) || (ren_valid && n_free == 1);

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      valid    <= '0;
      s1_valid <= 1'b0;
      fu_done  <= 1'b0;
    end else begin
      if (issue_valid) valid[issue_sel] <= 1'b0;
      if (ren_valid) valid[wr_sel] <= 1'b1;
      s1_valid <= issue_valid;
      fu_done  <= s1_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    for (int i = 0; i < STATION_SIZE; i++) begin
      if (ren_valid && wr_sel == slot_t'(i)) begin
        slot_op[i]  <= ren_op;
        slot_rob[i] <= ren_rob_index;
        a_ready[i]  <= op_a_valid;
        a_value[i]  <= op_a_value;
        a_tag[i]    <= op_a_tag;
        b_ready[i]  <= op_b_valid;
        b_value[i]  <= op_b_value;
        b_tag[i]    <= op_b_tag;
        age[i]      <= '0;
      end else begin
        if (bc_valid && !a_ready[i] && a_tag[i] == bc_index) begin
          a_ready[i] <= 1'b1;
          a_value[i] <= bc_value;
        end
        if (bc_valid && !b_ready[i] && b_tag[i] == bc_index) begin
          b_ready[i] <= 1'b1;
          b_value[i] <= bc_value;
        end
        // Older than the issued slot moves down one rank
        age[i] <= age[i] + slot_t'(ren_valid) -
                  slot_t'(issue_valid && age[i] > age[issue_sel]);
      end
    end
  end

  always_comb begin
    alu_op  = slot_op[issue_sel];
    alu_a   = a_value[issue_sel];
    alu_b   = b_value[issue_sel];
    alu_v   = 1'b0;
    case (alu_op)
      OP_ADD, OP_ADDS: begin
        alu_sum = {1'b0, alu_a} + {1'b0, alu_b};
        alu_v   = (alu_a[GPR_SIZE-1] == alu_b[GPR_SIZE-1]) &&
                  (alu_sum[GPR_SIZE-1] != alu_a[GPR_SIZE-1]);
      end
      OP_SUB, OP_SUBS: begin
        alu_sum = {1'b0, alu_a} + {1'b0, ~alu_b} + (GPR_SIZE + 1)'(1);  // Carry is no borrow
        alu_v   = (alu_a[GPR_SIZE-1] != alu_b[GPR_SIZE-1]) &&
                  (alu_sum[GPR_SIZE-1] != alu_a[GPR_SIZE-1]);
      end
      OP_AND:  alu_sum = {1'b0, alu_a & alu_b};
      OP_ORR:  alu_sum = {1'b0, alu_a | alu_b};
      default: alu_sum = {1'b0, alu_b};  // MOVZ
    endcase
  end

  always_ff @(posedge in_clk) begin
    s1_rob    <= slot_rob[issue_sel];
    s1_result <= alu_sum[GPR_SIZE-1:0];
    s1_c      <= alu_sum[GPR_SIZE];
    s1_v      <= alu_v;
    s1_set    <= (alu_op == OP_ADDS) || (alu_op == OP_SUBS);
    // Second stage forms NZCV
    fu_rob_index <= s1_rob;
    fu_value     <= s1_result;
    fu_set_nzcv  <= s1_set;
    fu_nzcv      <= {s1_result[GPR_SIZE-1], ~|s1_result, s1_c, s1_v};
  end

endmodule

`default_nettype wire

//--- src/ooo_backend_top.sv
`default_nettype none

module ooo_backend_top (
  input  logic                                    in_clk,
  input  logic                                    in_rst_n,
  input  logic                                    dispatch_valid,
  input  core_types_pkg::fu_op_t                  op,
  input  logic [core_types_pkg::GPR_IDX_SIZE-1:0] dst,
  input  logic [core_types_pkg::GPR_IDX_SIZE-1:0] src1,
  input  logic [core_types_pkg::GPR_IDX_SIZE-1:0] src2,
  input  logic                                    use_imm,
  input  logic [core_types_pkg::IMM_SIZE-1:0]     imm,
  output logic                                    stall,
  output logic                                    commit_valid,
  output logic [core_types_pkg::GPR_IDX_SIZE-1:0] commit_gpr,
  output logic [core_types_pkg::GPR_SIZE-1:0]     commit_value,
  output logic                                    commit_set_nzcv,
  output core_types_pkg::nzcv_t                   commit_nzcv,
  output core_types_pkg::nzcv_t                   flags
);
  import core_types_pkg::*;
  import rob_pkg::*;

  // Rename to ROB and station
  logic                    alloc_valid;
  logic [GPR_IDX_SIZE-1:0] alloc_gpr;
  logic                    alloc_set_nzcv;
  logic                    ren_valid;
  fu_op_t                  ren_op;
  logic                    ren_src_a_ready;
  logic [GPR_SIZE-1:0]     ren_src_a_value;
  logic [ROB_IDX_SIZE-1:0] ren_src_a_tag;
  logic                    ren_src_b_ready;
  logic [GPR_SIZE-1:0]     ren_src_b_value;
  logic [ROB_IDX_SIZE-1:0] ren_src_b_tag;
  logic [ROB_IDX_SIZE-1:0] ren_rob_index;
  logic [ROB_IDX_SIZE-1:0] rob_next_index;
  logic                    rob_full;
  logic                    station_full;
  logic [ROB_IDX_SIZE-1:0] commit_rob_index;

  // ROB to station, forwarded operands and broadcast
  logic                    op_a_valid;
  logic [GPR_SIZE-1:0]     op_a_value;
  logic [ROB_IDX_SIZE-1:0] op_a_tag;
  logic                    op_b_valid;
  logic [GPR_SIZE-1:0]     op_b_value;
  logic [ROB_IDX_SIZE-1:0] op_b_tag;
  logic                    bc_valid;
  logic [ROB_IDX_SIZE-1:0] bc_index;
  logic [GPR_SIZE-1:0]     bc_value;

  // ALU result into the ROB
  logic                    fu_done;
  logic [ROB_IDX_SIZE-1:0] fu_rob_index;
  logic [GPR_SIZE-1:0]     fu_value;
  logic                    fu_set_nzcv;
  nzcv_t                   fu_nzcv;

  reg_rename rename0 (.*);

  // Broadcast flags have no reader while NZCV consumers are absent
  rob rob0 (
    .bc_set_nzcv (),
    .bc_nzcv     (),
    .*
  );

  exec_station station0 (.*);

endmodule

`default_nettype wire

//--- src/reg_rename.sv
`default_nettype none

module reg_rename (
  input  logic                                    in_clk,
  input  logic                                    in_rst_n,
  input  logic                                    dispatch_valid,
  input  core_types_pkg::fu_op_t                  op,
  input  logic [core_types_pkg::GPR_IDX_SIZE-1:0] dst,
  input  logic [core_types_pkg::GPR_IDX_SIZE-1:0] src1,
  input  logic [core_types_pkg::GPR_IDX_SIZE-1:0] src2,
  input  logic                                    use_imm,
  input  logic [core_types_pkg::IMM_SIZE-1:0]     imm,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]        rob_next_index,
  input  logic                                    rob_full,
  input  logic                                    station_full,
  input  logic                                    commit_valid,
  input  logic [core_types_pkg::GPR_IDX_SIZE-1:0] commit_gpr,
  input  logic [core_types_pkg::GPR_SIZE-1:0]     commit_value,
  input  logic                                    commit_set_nzcv,
  input  core_types_pkg::nzcv_t                   commit_nzcv,
  input  logic [rob_pkg::ROB_IDX_SIZE-1:0]        commit_rob_index,
  output logic                                    stall,
  output logic                                    alloc_valid,
  output logic [core_types_pkg::GPR_IDX_SIZE-1:0] alloc_gpr,
  output logic                                    alloc_set_nzcv,
  output logic                                    ren_valid,
  output core_types_pkg::fu_op_t                  ren_op,
  output logic                                    ren_src_a_ready,
  output logic [core_types_pkg::GPR_SIZE-1:0]     ren_src_a_value,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]        ren_src_a_tag,
  output logic                                    ren_src_b_ready,
  output logic [core_types_pkg::GPR_SIZE-1:0]     ren_src_b_value,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]        ren_src_b_tag,
  output logic [rob_pkg::ROB_IDX_SIZE-1:0]        ren_rob_index,
  output core_types_pkg::nzcv_t                   flags
);
  import core_types_pkg::*;
  import rob_pkg::*;

  logic [GPR_SIZE-1:0]     gpr [GPR_COUNT];
  logic [ROB_IDX_SIZE-1:0] tag [GPR_COUNT];  // Youngest producer
  logic [GPR_COUNT-1:0]    busy;

  logic                    accept;
  logic                    a_ready;
  logic [GPR_SIZE-1:0]     a_value;
  logic [ROB_IDX_SIZE-1:0] a_tag;
  logic                    b_ready;
  logic [GPR_SIZE-1:0]     b_value;
  logic [ROB_IDX_SIZE-1:0] b_tag;

  // Returns {ready, value, tag} for one source
  function automatic logic [GPR_SIZE+ROB_IDX_SIZE:0] lookup(
      input logic [GPR_IDX_SIZE-1:0] idx);
    logic bypass;
    bypass = commit_valid && (commit_rob_index == tag[idx]);
    if (idx == ZERO_GPR) return {1'b1, GPR_SIZE'(0), tag[idx]};
    if (!busy[idx]) return {1'b1, gpr[idx], tag[idx]};
    if (bypass) return {1'b1, commit_value, tag[idx]};  // Producer retires this cycle
    return {1'b0, gpr[idx], tag[idx]};
  endfunction

  assign stall          = rob_full | station_full;
  assign accept         = dispatch_valid & ~stall;
  assign alloc_valid    = accept;
  assign alloc_gpr      = dst;
  assign alloc_set_nzcv = (op == OP_ADDS) || (op == OP_SUBS);

  always_comb begin
    {a_ready, a_value, a_tag} = lookup(src1);
    {b_ready, b_value, b_tag} = lookup(src2);
    if (use_imm) begin
      b_ready = 1'b1;
      b_value = GPR_SIZE'(imm);
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      for (int i = 0; i < GPR_COUNT; i++) begin
        gpr[i] <= '0;
        tag[i] <= '0;
      end
      busy  <= '0;
      flags <= '0;
    end else begin
      if (commit_valid) begin
        if (commit_gpr != ZERO_GPR) gpr[commit_gpr] <= commit_value;
        if (tag[commit_gpr] == commit_rob_index) busy[commit_gpr] <= 1'b0;
        if (commit_set_nzcv) flags <= commit_nzcv;
      end
      // A new producer overrides a clear from the commit above
      if (accept && dst != ZERO_GPR) begin
        busy[dst] <= 1'b1;
        tag[dst]  <= rob_next_index;
      end
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) ren_valid <= 1'b0;
    else ren_valid <= accept;
  end

  always_ff @(posedge in_clk) begin
    if (accept) begin
      ren_op          <= op;
      ren_src_a_ready <= a_ready;
      ren_src_a_value <= a_value;
      ren_src_a_tag   <= a_tag;
      ren_src_b_ready <= b_ready;
      ren_src_b_value <= b_value;
      ren_src_b_tag   <= b_tag;
      ren_rob_index   <= rob_next_index;
    end
  end

endmodule

`default_nettype wire
